// File: verilog/scalar_pkg.sv
package scalar_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////
	localparam int DATA_W  = 32;
	localparam int REG_N   = 16;
	localparam int INSTR_W = 16;
	localparam int ISSUE_W = 4;	// ROB depth must stay within 2**ISSUE_W

	typedef logic [DATA_W-1:0]        data_t;
	typedef logic [$clog2(REG_N)-1:0] reg_idx_t;
	typedef logic [INSTR_W-1:0]       instr_t;
	typedef logic [ISSUE_W-1:0]       issue_no_t;

	// Opcode field, instr[15:12]; unlisted codes are no-operations
	typedef enum logic [3:0] {
		OP_LDI  = 4'h1,	// dst <= zero-extended instr[7:0]
		OP_ADD  = 4'h2,
		OP_SUB  = 4'h3,
		OP_AND  = 4'h4,
		OP_OR   = 4'h5,
		OP_XOR  = 4'h6,
		OP_MUL  = 4'h7,	// Lower 32 bits of the product
		OP_HALT = 4'hf
	} opcode_t;

	////////////////////////////////////////////////////////////
	// Bundles
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		logic [7:0] adr;
		instr_t     dat;
	} wb_req_t;

	typedef struct packed {
		logic   ack;
		instr_t dat;
	} wb_rsp_t;

	typedef struct packed {
		opcode_t    op;
		reg_idx_t   dst;
		logic [7:0] imm;
		issue_no_t  issue_no;
		logic       write;	// Result goes to the register file
	} issue_t;

	typedef struct packed {
		logic      valid;
		issue_no_t issue_no;
		data_t     data;
	} result_t;

	typedef struct packed {
		logic      valid;
		issue_no_t issue_no;
		reg_idx_t  dst;
		logic      write;
		data_t     data;
	} commit_t;

endpackage

// File: verilog/instr_mem.sv
`timescale 1ns/1ps

module instr_mem #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic                clock,
	input  logic                reset,
	input  scalar_pkg::wb_req_t wb_req,
	output scalar_pkg::wb_rsp_t wb_rsp,
	input  logic [7:0]          fetch_addr,
	output scalar_pkg::instr_t  fetch_word
);

	scalar_pkg::instr_t mem [IMEM_DEPTH];
	scalar_pkg::instr_t rd_dat;
	logic               ack_q;
	logic               wb_sel;

	assign wb_sel = wb_req.cyc && wb_req.stb;

	// Classic cycle, ack one cycle after cyc/stb and held while they stay up
	always_ff @(posedge clock) begin
		if (reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= wb_sel;
		end
	end

	// Store on the first cycle of a write only
	always_ff @(posedge clock) begin
		if (wb_sel && wb_req.we && !ack_q) begin
			mem[wb_req.adr] <= wb_req.dat;
		end
		rd_dat <= mem[wb_req.adr];	// Readback word
	end

	// Never acknowledge a strobe the host has already dropped
	assign wb_rsp.ack = ack_q && wb_sel;
	assign wb_rsp.dat = rd_dat;

	// Fetch port reads straight from the array
	assign fetch_word = mem[fetch_addr];

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input  logic               clock,
	input  logic               reset,
	input  logic               start,
	output logic [7:0]         fetch_addr,
	input  scalar_pkg::instr_t fetch_word,
	output logic               instr_valid,
	output scalar_pkg::instr_t instr,
	input  logic               issue_ready,
	input  logic               rob_empty,
	output logic               busy,
	output logic               halted
);

	logic [7:0] pc;
	logic       halt_seen;	// HALT accepted by issue
	logic       accept;
	logic       is_halt;
	logic       load;

	assign fetch_addr = pc;
	assign accept     = instr_valid && issue_ready;
	assign is_halt    = scalar_pkg::opcode_t'(instr[15:12]) == scalar_pkg::OP_HALT;

	// Refill when the slot is free or being emptied, but not past HALT
	assign load = busy && !halt_seen && (!instr_valid || accept) && !(accept && is_halt);

	always_ff @(posedge clock) begin
		if (reset) begin
			pc          <= '0;
			busy        <= 1'b0;
			halted      <= 1'b0;
			halt_seen   <= 1'b0;
			instr_valid <= 1'b0;
		end else if (start) begin
			pc          <= '0;
			busy        <= 1'b1;
			halted      <= 1'b0;
			halt_seen   <= 1'b0;
			instr_valid <= 1'b0;
		end else begin
			if (load) begin
				pc          <= pc + 8'd1;
				instr_valid <= 1'b1;
			end else if (accept) begin
				instr_valid <= 1'b0;
			end
			if (accept && is_halt)
				halt_seen <= 1'b1;
			// Drained, HALT itself has committed
			if (busy && halt_seen && rob_empty) begin
				busy   <= 1'b0;
				halted <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (load)
			instr <= fetch_word;
	end

endmodule

// File: verilog/hazard_check.sv
`timescale 1ns/1ps

module hazard_check #(
	parameter int ROB_DEPTH = 8
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                instr_valid,
	input  scalar_pkg::instr_t  instr,
	output logic                issue_ready,
	input  logic                rob_full,
	input  scalar_pkg::commit_t commit,
	output scalar_pkg::issue_t  issue,
	output logic                issue_valid
);

	// Issue numbers index the ROB, so they must not alias within it
	if (ROB_DEPTH > 2 ** scalar_pkg::ISSUE_W) begin : g_depth_check
		$error("ROB_DEPTH exceeds the issue number range");
	end

	scalar_pkg::opcode_t         op;
	scalar_pkg::reg_idx_t        dst;
	scalar_pkg::reg_idx_t        src1;
	scalar_pkg::reg_idx_t        src2;
	logic                        reads;
	logic                        writes;
	logic                        hazard;
	logic [scalar_pkg::REG_N-1:0] pending;	// Scoreboard, one bit per register
	scalar_pkg::issue_no_t       next_no;
	logic [1:0]                  mul_hist;	// MUL issued one and two cycles back

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////
	assign op     = scalar_pkg::opcode_t'(instr[15:12]);
	assign dst    = instr[11:8];
	assign src1   = instr[7:4];
	assign src2   = instr[3:0];
	assign reads  = op inside {scalar_pkg::OP_ADD, scalar_pkg::OP_SUB, scalar_pkg::OP_AND,
		scalar_pkg::OP_OR, scalar_pkg::OP_XOR, scalar_pkg::OP_MUL};
	assign writes = reads || op == scalar_pkg::OP_LDI;

	// A non-MUL issued two cycles after a MUL would share its result slot
	assign hazard = (reads && (pending[src1] || pending[src2]))
		|| (writes && pending[dst])
		|| (mul_hist[1] && op != scalar_pkg::OP_MUL);

	assign issue_ready = !rob_full && !hazard;
	assign issue_valid = instr_valid && issue_ready;

	assign issue = '{op: op, dst: dst, imm: instr[7:0], issue_no: next_no, write: writes};

	always_ff @(posedge clock) begin
		if (reset) begin
			pending  <= '0;
			next_no  <= '0;
			mul_hist <= '0;
		end else begin
			if (commit.valid && commit.write)
				pending[commit.dst] <= 1'b0;
			if (issue_valid && writes)
				pending[dst] <= 1'b1;	// Never the register just cleared
			if (issue_valid)
				next_no <= next_no + 1'b1;
			mul_hist <= {mul_hist[0], issue_valid && op == scalar_pkg::OP_MUL};
		end
	end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                 clock,
	input  logic                 reset,
	input  scalar_pkg::reg_idx_t src1,
	input  scalar_pkg::reg_idx_t src2,
	output scalar_pkg::data_t    data1,
	output scalar_pkg::data_t    data2,
	input  scalar_pkg::commit_t  commit
);

	scalar_pkg::data_t regs [scalar_pkg::REG_N];

	// Architectural state, written only at commit
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < scalar_pkg::REG_N; i++)
				regs[i] <= '0;
		end else if (commit.valid && commit.write) begin
			regs[commit.dst] <= commit.data;
		end
	end

	// Operands land one cycle after issue, old value on a same-cycle write
	always_ff @(posedge clock) begin
		data1 <= regs[src1];
		data2 <= regs[src2];
	end

endmodule

// File: verilog/math_unit.sv
`timescale 1ns/1ps

module math_unit (
	input  logic                clock,
	input  logic                reset,
	input  scalar_pkg::issue_t  issue,
	input  logic                issue_valid,
	input  scalar_pkg::data_t   data1,
	input  scalar_pkg::data_t   data2,
	output scalar_pkg::result_t result
);

	scalar_pkg::issue_t    op_q;	// Waits one cycle for register read
	logic                  op_v;
	logic                  is_mul;
	scalar_pkg::data_t     alu_out;

	logic                  m1_v;
	logic                  m2_v;
	scalar_pkg::issue_no_t m1_no;
	scalar_pkg::issue_no_t m2_no;
	scalar_pkg::data_t     m1_a;
	scalar_pkg::data_t     m1_b;
	scalar_pkg::data_t     m2_p;

	logic                  res_v;
	scalar_pkg::issue_no_t res_no;
	scalar_pkg::data_t     res_data;

	assign is_mul = op_q.op == scalar_pkg::OP_MUL;

	////////////////////////////////////////////////////////////
	// ALU, one cycle
	////////////////////////////////////////////////////////////
	always_comb begin
		case (op_q.op)
			scalar_pkg::OP_LDI: alu_out = scalar_pkg::data_t'(op_q.imm);
			scalar_pkg::OP_ADD: alu_out = data1 + data2;
			scalar_pkg::OP_SUB: alu_out = data1 - data2;
			scalar_pkg::OP_AND: alu_out = data1 & data2;
			scalar_pkg::OP_OR:  alu_out = data1 | data2;
			scalar_pkg::OP_XOR: alu_out = data1 ^ data2;
			default:            alu_out = '0;	// HALT and no-ops commit zero
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			op_v  <= 1'b0;
			m1_v  <= 1'b0;
			m2_v  <= 1'b0;
			res_v <= 1'b0;
		end else begin
			op_v  <= issue_valid;
			m1_v  <= op_v && is_mul;
			m2_v  <= m1_v;
			res_v <= (op_v && !is_mul) || m2_v;
		end
	end

	// Multiplier stages: operands, product, result bus
	always_ff @(posedge clock) begin
		op_q  <= issue;
		m1_a  <= data1;
		m1_b  <= data2;
		m1_no <= op_q.issue_no;
		m2_p  <= m1_a * m1_b;	// Lower half kept
		m2_no <= m1_no;
		if (m2_v) begin
			res_no   <= m2_no;
			res_data <= m2_p;
		end else begin
			res_no   <= op_q.issue_no;
			res_data <= alu_out;
		end
	end

	assign result = '{valid: res_v, issue_no: res_no, data: res_data};

endmodule

// File: verilog/reorder_buff.sv
`timescale 1ns/1ps

module reorder_buff #(
	parameter int ROB_DEPTH = 8	// Power of two, so issue numbers wrap cleanly
) (
	input  logic                clock,
	input  logic                reset,
	input  scalar_pkg::issue_t  issue,
	input  logic                issue_valid,
	input  scalar_pkg::result_t result,
	output scalar_pkg::commit_t commit,
	output logic                full,
	output logic                empty
);

	localparam int IDX_W = (ROB_DEPTH > 1) ? $clog2(ROB_DEPTH) : 1;
	localparam int CNT_W = $clog2(ROB_DEPTH + 1);

	scalar_pkg::reg_idx_t  ent_dst   [ROB_DEPTH];
	logic                  ent_write [ROB_DEPTH];
	scalar_pkg::data_t     ent_data  [ROB_DEPTH];
	logic [ROB_DEPTH-1:0]  ent_done;

	scalar_pkg::issue_no_t head_no;	// Oldest uncommitted issue number
	logic [CNT_W-1:0]      count;
	logic [IDX_W-1:0]      alloc_idx;
	logic [IDX_W-1:0]      res_idx;
	logic [IDX_W-1:0]      head_idx;
	logic                  do_commit;

	assign alloc_idx = IDX_W'(issue.issue_no % ROB_DEPTH);
	assign res_idx   = IDX_W'(result.issue_no % ROB_DEPTH);
	assign head_idx  = IDX_W'(head_no % ROB_DEPTH);

	assign full  = count == CNT_W'(ROB_DEPTH);
	assign empty = count == '0;

	////////////////////////////////////////////////////////////
	// In-order commit from the head
	////////////////////////////////////////////////////////////
	assign do_commit = ent_done[head_idx];
	assign commit = '{
		valid:    do_commit,
		issue_no: head_no,
		dst:      ent_dst[head_idx],
		write:    ent_write[head_idx],
		data:     ent_data[head_idx]
	};

	always_ff @(posedge clock) begin
		if (reset) begin
			ent_done <= '0;
			head_no  <= '0;
			count    <= '0;
		end else begin
			if (result.valid)
				ent_done[res_idx] <= 1'b1;
			if (do_commit) begin
				ent_done[head_idx] <= 1'b0;
				head_no            <= head_no + 1'b1;
			end
			count <= count + CNT_W'(issue_valid) - CNT_W'(do_commit);
		end
	end

	// Entry payload
	always_ff @(posedge clock) begin
		if (issue_valid) begin
			ent_dst[alloc_idx]   <= issue.dst;
			ent_write[alloc_idx] <= issue.write;
		end
		if (result.valid)
			ent_data[res_idx] <= result.data;
	end

endmodule

// File: verilog/scalar_core.sv
`timescale 1ns/1ps

module scalar_core #(
	parameter int IMEM_DEPTH = 256,
	parameter int ROB_DEPTH  = 8
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 start,
	input  scalar_pkg::wb_req_t  wb_req,
	output scalar_pkg::wb_rsp_t  wb_rsp,
	output scalar_pkg::commit_t  commit,
	output logic                 busy,
	output logic                 halted
);

	logic [7:0]           fetch_addr;
	scalar_pkg::instr_t   fetch_word;
	logic                 instr_valid;
	scalar_pkg::instr_t   instr;
	logic                 issue_ready;
	scalar_pkg::issue_t   issue;
	logic                 issue_valid;
	scalar_pkg::data_t    data1;
	scalar_pkg::data_t    data2;
	scalar_pkg::result_t  result;
	logic                 rob_full;
	logic                 rob_empty;

	////////////////////////////////////////////////////////////
	// Front end
	////////////////////////////////////////////////////////////
	instr_mem #(.IMEM_DEPTH(IMEM_DEPTH)) u_imem (
		.clock(clock), .reset(reset),
		.wb_req(wb_req), .wb_rsp(wb_rsp),
		.fetch_addr(fetch_addr), .fetch_word(fetch_word)
	);

	fetch_unit u_fetch (
		.clock(clock), .reset(reset), .start(start),
		.fetch_addr(fetch_addr), .fetch_word(fetch_word),
		.instr_valid(instr_valid), .instr(instr), .issue_ready(issue_ready),
		.rob_empty(rob_empty), .busy(busy), .halted(halted)
	);

	hazard_check #(.ROB_DEPTH(ROB_DEPTH)) u_hazard (
		.clock(clock), .reset(reset),
		.instr_valid(instr_valid), .instr(instr), .issue_ready(issue_ready),
		.rob_full(rob_full), .commit(commit),
		.issue(issue), .issue_valid(issue_valid)
	);

	////////////////////////////////////////////////////////////
	// Back end
	////////////////////////////////////////////////////////////
	reg_file u_regs (
		.clock(clock), .reset(reset),
		.src1(instr[7:4]), .src2(instr[3:0]),	// Read in the issue cycle
		.data1(data1), .data2(data2), .commit(commit)
	);

	math_unit u_math (
		.clock(clock), .reset(reset),
		.issue(issue), .issue_valid(issue_valid),
		.data1(data1), .data2(data2), .result(result)
	);

	reorder_buff #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
		.clock(clock), .reset(reset),
		.issue(issue), .issue_valid(issue_valid), .result(result),
		.commit(commit), .full(rob_full), .empty(rob_empty)
	);

endmodule

// File: tb/scalar_core_checker.sv
`timescale 1ns/1ps

module scalar_core_checker (
	input logic                clock,
	input logic                reset,
	input scalar_pkg::wb_req_t wb_req,
	input scalar_pkg::wb_rsp_t wb_rsp,
	input scalar_pkg::commit_t commit,
	input logic                halted
);

	int                    fail_count;
	scalar_pkg::issue_no_t last_no;	// Issue number of the previous commit
	logic                  seen;

	initial fail_count = 0;

	always_ff @(posedge clock) begin
		if (reset) begin
			seen    <= 1'b0;
			last_no <= '0;
		end else if (commit.valid) begin
			seen    <= 1'b1;
			last_no <= commit.issue_no;
		end
	end

	////////////////////////////////////////////////////////////
	// Properties
	////////////////////////////////////////////////////////////
	ack_needs_stb: assert property (@(posedge clock) disable iff (reset)
		wb_rsp.ack |-> wb_req.stb)
		else begin
			fail_count++;
			$error("Wishbone ack is high while stb is low");
		end

	// Commits step the issue number by one, wrapping
	commit_in_order: assert property (@(posedge clock) disable iff (reset)
		commit.valid && seen |-> commit.issue_no == scalar_pkg::issue_no_t'(last_no + 1'b1))
		else begin
			fail_count++;
			$error("Commit issue number does not follow the previous one");
		end

	no_commit_halted: assert property (@(posedge clock) disable iff (reset)
		halted |-> !commit.valid)
		else begin
			fail_count++;
			$error("Commit seen while the core is halted");
		end

endmodule

bind scalar_core scalar_core_checker u_chk (
	.clock(clock), .reset(reset), .wb_req(wb_req), .wb_rsp(wb_rsp),
	.commit(commit), .halted(halted)
);

// File: tb/scalar_core_tb.sv
`timescale 1ns/1ps

module scalar_core_tb;

	logic                clock;
	logic                reset;
	logic                start;
	scalar_pkg::wb_req_t wb_req;
	scalar_pkg::wb_rsp_t wb_rsp;
	scalar_pkg::commit_t commit;
	logic                busy;
	logic                halted;

	scalar_pkg::instr_t  table_word [$];	// One row per instruction
	scalar_pkg::commit_t table_exp [$];
	int                  prog_first [$];
	int                  prog_len [$];
	logic                table_ready;
	scalar_pkg::data_t   model_regs [scalar_pkg::REG_N];
	scalar_pkg::issue_no_t model_no;
	logic [31:0]         lfsr_state;

	// Shallow ROB so that a MUL burst can fill it
	scalar_core #(.IMEM_DEPTH(256), .ROB_DEPTH(4)) uut (
		.clock(clock), .reset(reset), .start(start), .wb_req(wb_req), .wb_rsp(wb_rsp),
		.commit(commit), .busy(busy), .halted(halted)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
			$display("*** FAILED ***");
			$fatal(1, "Run stopped at the first error");
		end
	endtask

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v          = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic scalar_pkg::instr_t encode_op(input scalar_pkg::opcode_t op,
		input logic [3:0] d, input logic [3:0] a, input logic [3:0] b);
		return {op, d, a, b};
	endfunction

	function automatic scalar_pkg::instr_t encode_ldi(input logic [3:0] d,
		input logic [7:0] imm);
		return {scalar_pkg::OP_LDI, d, imm};
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model stepping one word in program order
	////////////////////////////////////////////////////////////
	function automatic scalar_pkg::commit_t model_step(input scalar_pkg::instr_t word);
		logic [3:0]        op;
		scalar_pkg::data_t x;
		scalar_pkg::data_t y;
		scalar_pkg::data_t val;
		logic              wr;
		scalar_pkg::commit_t c;
		op  = word[15:12];
		x   = model_regs[word[7:4]];
		y   = model_regs[word[3:0]];
		wr  = 1'b1;
		case (op)
			scalar_pkg::OP_LDI: val = {24'd0, word[7:0]};
			scalar_pkg::OP_ADD: val = x + y;
			scalar_pkg::OP_SUB: val = x - y;
			scalar_pkg::OP_AND: val = x & y;
			scalar_pkg::OP_OR:  val = x | y;
			scalar_pkg::OP_XOR: val = x ^ y;
			scalar_pkg::OP_MUL: val = x * y;
			default: begin
				val = '0;	// HALT and no-ops commit without a write
				wr  = 1'b0;
			end
		endcase
		if (wr)
			model_regs[word[11:8]] = val;
		c = '{valid: 1'b1, issue_no: model_no, dst: word[11:8], write: wr, data: val};
		model_no = model_no + 4'd1;
		return c;
	endfunction

	task automatic new_program();
		prog_first.push_back(table_word.size());
		prog_len.push_back(0);
	endtask

	task automatic add_row(input scalar_pkg::instr_t word);
		table_word.push_back(word);
		table_exp.push_back(model_step(word));
		prog_len[prog_len.size()-1] += 1;
	endtask

	task automatic add_random_program(input int n);
		logic [2:0]  sel;
		logic [11:0] fields;
		new_program();
		for (int i = 0; i < n; i++) begin
			sel    = 3'(lfsr_bits(3));	// Code 0 gives a no-op
			fields = 12'(lfsr_bits(12));
			add_row({1'b0, sel, fields});
		end
		add_row(encode_op(scalar_pkg::OP_HALT, 0, 0, 0));
	endtask

	// One classic cycle held until ack
	task automatic wb_access(input logic we, input logic [7:0] adr,
		input scalar_pkg::instr_t dat, output scalar_pkg::instr_t rdat);
		@(posedge clock);
		#1 wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		do @(negedge clock); while (!wb_rsp.ack);
		rdat = wb_rsp.dat;
		@(posedge clock);
		#1 wb_req = '0;
	endtask

	task automatic run_program(input int p);
		int                  first;
		int                  len;
		int                  got;
		scalar_pkg::instr_t  rdat;
		scalar_pkg::commit_t exp;
		first = prog_first[p];
		len   = prog_len[p];
		for (int i = 0; i < len; i++)
			wb_access(1'b1, 8'(i), table_word[first+i], rdat);
		for (int i = 0; i < len; i++) begin
			wb_access(1'b0, 8'(i), '0, rdat);
			check_value("wb_rsp.dat", rdat, table_word[first+i]);
		end
		@(posedge clock);
		#1 start = 1'b1;
		@(posedge clock);
		#1 start = 1'b0;
		check_value("busy", busy, 1);
		got = 0;
		while (got < len) begin
			@(negedge clock);
			if (commit.valid) begin
				exp = table_exp[first+got];
				check_value("commit.issue_no", commit.issue_no, exp.issue_no);
				check_value("commit.dst", commit.dst, exp.dst);
				check_value("commit.write", commit.write, exp.write);
				check_value("commit.data", commit.data, exp.data);
				got++;
			end
		end
		while (!halted) begin	// Nothing more may commit after HALT
			@(negedge clock);
			check_value("commit.valid", commit.valid, 0);
		end
		check_value("busy", busy, 0);
	endtask

	initial begin : watchdog
		wait (table_ready);
		repeat (200 * table_word.size()) @(posedge clock);
		$display("Timeout: the run did not finish within %0d cycles", 200 * table_word.size());
		$display("*** FAILED ***");
		$fatal(1, "Watchdog expired");
	end

	initial begin : main
		reset       = 1'b1;
		start       = 1'b0;
		wb_req      = '0;
		table_ready = 1'b0;
		lfsr_state  = 32'hdebc;
		model_no    = '0;
		for (int i = 0; i < scalar_pkg::REG_N; i++)
			model_regs[i] = '0;

		new_program();	// Plain ALU work
		add_row(encode_ldi(1, 8'd5));
		add_row(encode_ldi(2, 8'd12));
		add_row(encode_op(scalar_pkg::OP_ADD, 3, 1, 2));
		add_row(encode_op(scalar_pkg::OP_SUB, 4, 2, 1));
		add_row(encode_op(scalar_pkg::OP_AND, 5, 1, 2));
		add_row(encode_op(scalar_pkg::OP_OR, 6, 1, 2));
		add_row(encode_op(scalar_pkg::OP_XOR, 7, 1, 2));
		add_row(encode_op(scalar_pkg::OP_HALT, 0, 0, 0));
		new_program();	// Dependent chain through MUL
		add_row(encode_ldi(1, 8'd3));
		add_row(encode_ldi(2, 8'd7));
		add_row(encode_op(scalar_pkg::OP_MUL, 3, 1, 2));
		add_row(encode_op(scalar_pkg::OP_MUL, 4, 3, 3));
		add_row(encode_op(scalar_pkg::OP_MUL, 5, 4, 1));
		add_row(encode_op(scalar_pkg::OP_ADD, 6, 5, 3));
		add_row(encode_op(scalar_pkg::OP_HALT, 0, 0, 0));
		new_program();	// MUL overtaken by independent ALU ops
		add_row(encode_ldi(8, 8'd200));
		add_row(encode_ldi(9, 8'd150));
		add_row(encode_op(scalar_pkg::OP_MUL, 10, 8, 9));
		add_row(encode_ldi(11, 8'd9));
		add_row(encode_op(scalar_pkg::OP_ADD, 12, 8, 9));
		add_row(encode_op(scalar_pkg::OP_XOR, 13, 11, 8));
		add_row(encode_op(scalar_pkg::OP_SUB, 14, 9, 8));
		add_row(encode_op(scalar_pkg::OP_HALT, 0, 0, 0));
		new_program();	// Independent MULs fill the ROB
		add_row(encode_op(scalar_pkg::OP_MUL, 1, 8, 9));
		add_row(encode_op(scalar_pkg::OP_MUL, 2, 8, 9));
		add_row(encode_op(scalar_pkg::OP_MUL, 3, 8, 9));
		add_row(encode_op(scalar_pkg::OP_MUL, 4, 8, 9));
		add_row(encode_op(scalar_pkg::OP_MUL, 5, 8, 9));
		add_row(encode_op(scalar_pkg::OP_HALT, 0, 0, 0));
		add_random_program(20);	// Longer than the ROB
		add_random_program(20);
		table_ready = 1'b1;

		repeat (3) @(posedge clock);
		#1 reset = 1'b0;
		check_value("busy", busy, 0);
		check_value("halted", halted, 0);
		check_value("commit.valid", commit.valid, 0);
		check_value("wb_rsp.ack", wb_rsp.ack, 0);

		for (int p = 0; p < prog_first.size(); p++)
			run_program(p);

		if (uut.u_chk.fail_count == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			$display("*** FAILED ***");
			$fatal(1, "Assertion failures were reported");
		end
	end

endmodule

// File: scalar_core.f
verilog/scalar_pkg.sv
verilog/instr_mem.sv
verilog/fetch_unit.sv
verilog/hazard_check.sv
verilog/reg_file.sv
verilog/math_unit.sv
verilog/reorder_buff.sv
verilog/scalar_core.sv
tb/scalar_core_checker.sv
tb/scalar_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the fail message in the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module scalar_core_tb \
	-f scalar_core.f -o scalar_core_sim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/scalar_core_sim > sim.log 2>&1 \
	|| echo "*** FAILED *** (simulator returned an error status)" >> sim.log
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "Simulation failed"; exit 1; } \
	|| echo "Simulation passed"
exit 0
